// File: verilog/sys_bus_defines.svh
/*
 * Widths, queue depth, register map and response codes
 * shared by the AXI to system bus bridge
 */
`ifndef SYS_BUS_DEFINES_SVH
`define SYS_BUS_DEFINES_SVH

// Bus widths
`define SB_AW 32
`define SB_DW 32
`define SB_IW 12

// Entries in each request/response queue, power of two
`define SB_FIFO_DEPTH 4

// Register map
`define SB_REG_NUM  8
`define SB_ID_VALUE 32'h5250_0001

// AXI response codes
`define SB_RESP_OKAY   2'd0
`define SB_RESP_SLVERR 2'd2

`endif

// File: verilog/sys_bus_pkg.sv
/*
 * AXI channel structs, queued request/response structs
 * and system bus command/answer structs
 */
package sys_bus_pkg;

`include "sys_bus_defines.svh"

  ////////////////////////////////////////
  // AXI channels
  ////////////////////////////////////////

  typedef struct packed {
    logic [`SB_IW-1:0] id;
    logic [`SB_AW-1:0] addr;
  } axi_aw_t;

  typedef struct packed {
    logic [`SB_DW-1:0]   data;
    logic [`SB_DW/8-1:0] strb;
  } axi_w_t;

  typedef struct packed {
    logic [`SB_IW-1:0] id;
    logic [`SB_AW-1:0] addr;
  } axi_ar_t;

  typedef struct packed {
    logic [`SB_IW-1:0] id;
    logic [1:0]        resp;
  } axi_b_t;

  typedef struct packed {
    logic [`SB_IW-1:0] id;
    logic [`SB_DW-1:0] data;
    logic [1:0]        resp;
  } axi_r_t;

  ////////////////////////////////////////
  // Queue entries
  ////////////////////////////////////////

  typedef struct packed {
    logic                we;
    logic [`SB_IW-1:0]   id;
    logic [`SB_AW-1:0]   addr;
    logic [`SB_DW-1:0]   wdata;
    logic [`SB_DW/8-1:0] wstrb;
  } bus_req_t;

  typedef struct packed {
    logic              we;
    logic [`SB_IW-1:0] id;
    logic [`SB_DW-1:0] rdata;
    logic [1:0]        resp;
  } bus_rsp_t;

  ////////////////////////////////////////
  // System bus
  ////////////////////////////////////////

  typedef struct packed {
    logic                wen;
    logic                ren;
    logic [`SB_AW-1:0]   addr;
    logic [`SB_DW-1:0]   wdata;
    logic [`SB_DW/8-1:0] sel;
  } sys_req_t;

  typedef struct packed {
    logic              ack;
    logic              err;
    logic [`SB_DW-1:0] rdata;
  } sys_rsp_t;

endpackage

// File: verilog/sync_fifo.sv
/*
 * Synchronous FIFO, payload type given by parameter
 */
`timescale 1ns/1ps

`include "sys_bus_defines.svh"

module sync_fifo #(
  parameter type T     = logic,
  parameter int  DEPTH = `SB_FIFO_DEPTH
) (
  input  logic clk_i,
  input  logic rst_i,
  input  T     data_i,
  input  logic push_i,
  input  logic pop_i,
  output T     data_o,
  output logic full_o,
  output logic empty_o
);

  // Pointer width, DEPTH of at least 2
  localparam int PW = $clog2(DEPTH);

  T           mem [DEPTH];
  logic [PW:0] wr_ptr;
  logic [PW:0] rd_ptr;
  logic        do_push;
  logic        do_pop;

  assign do_push = push_i && !full_o;
  assign do_pop  = pop_i && !empty_o;

  // Wrap bits differ and indexes match when full
  assign empty_o = (wr_ptr == rd_ptr);
  assign full_o  = (wr_ptr[PW] != rd_ptr[PW]) && (wr_ptr[PW-1:0] == rd_ptr[PW-1:0]);
  assign data_o  = mem[rd_ptr[PW-1:0]];

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_push) wr_ptr <= wr_ptr + 1'b1;
      if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_push) mem[wr_ptr[PW-1:0]] <= data_i;
  end

endmodule

// File: verilog/axi_slave_front.sv
/*
 * AXI slave front end: address/data handshakes, request
 * building and B/R response return from the response queue
 */
`timescale 1ns/1ps

module axi_slave_front (
  input  logic                  clk_i,
  input  logic                  rst_i,
  // AXI write address and data
  input  sys_bus_pkg::axi_aw_t  aw_i,
  input  logic                  awvalid_i,
  output logic                  awready_o,
  input  sys_bus_pkg::axi_w_t   w_i,
  input  logic                  wvalid_i,
  output logic                  wready_o,
  // AXI read address
  input  sys_bus_pkg::axi_ar_t  ar_i,
  input  logic                  arvalid_i,
  output logic                  arready_o,
  // AXI write response
  output sys_bus_pkg::axi_b_t   b_o,
  output logic                  bvalid_o,
  input  logic                  bready_i,
  // AXI read data
  output sys_bus_pkg::axi_r_t   r_o,
  output logic                  rvalid_o,
  input  logic                  rready_i,
  // Request queue
  output sys_bus_pkg::bus_req_t req_o,
  output logic                  req_push_o,
  input  logic                  req_full_i,
  // Response queue head
  input  sys_bus_pkg::bus_rsp_t rsp_i,
  input  logic                  rsp_empty_i,
  output logic                  rsp_pop_o
);

  logic accept_en;
  logic wr_acc;
  logic rd_acc;

  // No address is taken until the first cycle out of reset
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      accept_en <= 1'b0;
    end else begin
      accept_en <= 1'b1;
    end
  end

  ////////////////////////////////////////
  // Request side
  ////////////////////////////////////////

  // Write needs both AW and W present, and wins over a read
  assign wr_acc = accept_en && awvalid_i && wvalid_i && !req_full_i;
  assign rd_acc = accept_en && arvalid_i && !wr_acc && !req_full_i;

  assign awready_o  = wr_acc;
  assign wready_o   = wr_acc;
  assign arready_o  = rd_acc;
  assign req_push_o = wr_acc || rd_acc;

  always_comb begin
    req_o.we = wr_acc;
    if (wr_acc) begin
      req_o.id    = aw_i.id;
      req_o.addr  = aw_i.addr;
      req_o.wstrb = w_i.strb;
    end else begin
      req_o.id    = ar_i.id;
      req_o.addr  = ar_i.addr;
      req_o.wstrb = '0;
    end
    req_o.wdata = w_i.data;
  end

  ////////////////////////////////////////
  // Response side
  ////////////////////////////////////////

  // Queue head goes to B for writes, R for reads
  assign bvalid_o = !rsp_empty_i && rsp_i.we;
  assign rvalid_o = !rsp_empty_i && !rsp_i.we;

  assign b_o.id   = rsp_i.id;
  assign b_o.resp = rsp_i.resp;

  assign r_o.id   = rsp_i.id;
  assign r_o.data = rsp_i.rdata;
  assign r_o.resp = rsp_i.resp;

  assign rsp_pop_o = (bvalid_o && bready_i) || (rvalid_o && rready_i);

endmodule

// File: verilog/sys_bus_master.sv
/*
 * System bus master: plays queued requests as single strobes
 * and queues the acknowledged results
 */
`timescale 1ns/1ps

`include "sys_bus_defines.svh"

module sys_bus_master (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  sys_bus_pkg::bus_req_t req_i,
  input  logic                  req_empty_i,
  output logic                  req_pop_o,
  output sys_bus_pkg::sys_req_t sys_req_o,
  input  sys_bus_pkg::sys_rsp_t sys_rsp_i,
  output sys_bus_pkg::bus_rsp_t rsp_o,
  output logic                  rsp_push_o,
  input  logic                  rsp_full_i
);

  typedef enum logic [1:0] {ST_IDLE, ST_BUSY, ST_HOLD} state_t;

  state_t            state;
  logic              wen_q;
  logic              ren_q;
  logic [`SB_AW-1:0] cmd_addr;
  logic [`SB_DW-1:0] cmd_wdata;
  logic [`SB_DW/8-1:0] cmd_sel;
  logic              pend_we;
  logic [`SB_IW-1:0] pend_id;
  logic [`SB_DW-1:0] hold_rdata;
  logic [1:0]        hold_resp;
  logic [1:0]        ack_resp;
  logic              ack_now;

  assign req_pop_o = (state == ST_IDLE) && !req_empty_i;
  assign ack_now   = (state == ST_BUSY) && sys_rsp_i.ack;
  assign ack_resp  = sys_rsp_i.err ? `SB_RESP_SLVERR : `SB_RESP_OKAY;

  ////////////////////////////////////////
  // FSM
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      state <= ST_IDLE;
      wen_q <= 1'b0;
      ren_q <= 1'b0;
    end else begin
      // Strobes last one cycle
      wen_q <= 1'b0;
      ren_q <= 1'b0;
      case (state)
        ST_IDLE: begin
          if (!req_empty_i) begin
            wen_q <= req_i.we;
            ren_q <= !req_i.we;
            state <= ST_BUSY;
          end
        end
        ST_BUSY: begin
          if (sys_rsp_i.ack) state <= rsp_full_i ? ST_HOLD : ST_IDLE;
        end
        ST_HOLD: begin
          if (!rsp_full_i) state <= ST_IDLE;
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // Command and pending result payload
  always_ff @(posedge clk_i) begin
    if (req_pop_o) begin
      cmd_addr  <= req_i.addr;
      cmd_wdata <= req_i.wdata;
      cmd_sel   <= req_i.wstrb;
      pend_we   <= req_i.we;
      pend_id   <= req_i.id;
    end
    if (ack_now) begin
      hold_rdata <= sys_rsp_i.rdata;
      hold_resp  <= ack_resp;
    end
  end

  assign sys_req_o.wen   = wen_q;
  assign sys_req_o.ren   = ren_q;
  assign sys_req_o.addr  = cmd_addr;
  assign sys_req_o.wdata = cmd_wdata;
  assign sys_req_o.sel   = cmd_sel;

  // Result goes straight out on ack, or from hold once there is room
  assign rsp_push_o  = (ack_now || (state == ST_HOLD)) && !rsp_full_i;
  assign rsp_o.we    = pend_we;
  assign rsp_o.id    = pend_id;
  assign rsp_o.rdata = (state == ST_HOLD) ? hold_rdata : sys_rsp_i.rdata;
  assign rsp_o.resp  = (state == ST_HOLD) ? hold_resp : ack_resp;

endmodule

// File: verilog/ctrl_regs.sv
/*
 * Control registers on the system bus: read-only ID at word 0,
 * seven byte-writable registers, error on bad access
 */
`timescale 1ns/1ps

`include "sys_bus_defines.svh"

module ctrl_regs (
  input  logic                  clk_i,
  input  logic                  rst_i,
  input  sys_bus_pkg::sys_req_t sys_req_i,
  output sys_bus_pkg::sys_rsp_t sys_rsp_o
);

  localparam int RW = $clog2(`SB_REG_NUM);

  logic [`SB_DW-1:0] regs [1:`SB_REG_NUM-1];
  logic [RW-1:0]     idx;
  logic              in_range;
  logic              wr_en;
  logic [`SB_DW-1:0] rd_word;
  logic              acc_err;
  logic              ack_q;
  logic              err_q;
  logic [`SB_DW-1:0] rdata_q;

  // Word select, byte offset ignored
  assign idx      = sys_req_i.addr[RW+1:2];
  assign in_range = (sys_req_i.addr < `SB_REG_NUM * 4);
  assign wr_en    = sys_req_i.wen && in_range && (idx != '0);

  always_comb begin
    rd_word = '0;
    acc_err = 1'b0;
    if (!in_range) begin
      acc_err = 1'b1;
    end else if (idx == '0) begin
      rd_word = `SB_ID_VALUE;
      acc_err = sys_req_i.wen;
    end else begin
      rd_word = regs[idx];
    end
  end

  ////////////////////////////////////////
  // Register file
  ////////////////////////////////////////

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      for (int i = 1; i < `SB_REG_NUM; i++) regs[i] <= '0;
    end else if (wr_en) begin
      for (int b = 0; b < `SB_DW/8; b++) begin
        if (sys_req_i.sel[b]) regs[idx][8*b +: 8] <= sys_req_i.wdata[8*b +: 8];
      end
    end
  end

  // Answer one cycle after the strobe
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      ack_q <= 1'b0;
    end else begin
      ack_q <= sys_req_i.wen || sys_req_i.ren;
    end
  end

  always_ff @(posedge clk_i) begin
    err_q   <= acc_err;
    rdata_q <= rd_word;
  end

  assign sys_rsp_o.ack   = ack_q;
  assign sys_rsp_o.err   = err_q;
  assign sys_rsp_o.rdata = rdata_q;

endmodule

// File: verilog/ps_axi_bridge.sv
/*
 * AXI slave port to system bus bridge with control registers
 */
`timescale 1ns/1ps

module ps_axi_bridge (
  input  logic                 clk_i,
  input  logic                 rst_i,
  input  sys_bus_pkg::axi_aw_t aw_i,
  input  logic                 awvalid_i,
  output logic                 awready_o,
  input  sys_bus_pkg::axi_w_t  w_i,
  input  logic                 wvalid_i,
  output logic                 wready_o,
  input  sys_bus_pkg::axi_ar_t ar_i,
  input  logic                 arvalid_i,
  output logic                 arready_o,
  output sys_bus_pkg::axi_b_t  b_o,
  output logic                 bvalid_o,
  input  logic                 bready_i,
  output sys_bus_pkg::axi_r_t  r_o,
  output logic                 rvalid_o,
  input  logic                 rready_i
);

  sys_bus_pkg::bus_req_t req_in;
  sys_bus_pkg::bus_req_t req_head;
  logic                  req_push;
  logic                  req_pop;
  logic                  req_full;
  logic                  req_empty;

  sys_bus_pkg::bus_rsp_t rsp_in;
  sys_bus_pkg::bus_rsp_t rsp_head;
  logic                  rsp_push;
  logic                  rsp_pop;
  logic                  rsp_full;
  logic                  rsp_empty;

  sys_bus_pkg::sys_req_t sys_req;
  sys_bus_pkg::sys_rsp_t sys_rsp;

  ////////////////////////////////////////
  // AXI side
  ////////////////////////////////////////

  axi_slave_front i_axi_slave_front (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .aw_i        (aw_i),
    .awvalid_i   (awvalid_i),
    .awready_o   (awready_o),
    .w_i         (w_i),
    .wvalid_i    (wvalid_i),
    .wready_o    (wready_o),
    .ar_i        (ar_i),
    .arvalid_i   (arvalid_i),
    .arready_o   (arready_o),
    .b_o         (b_o),
    .bvalid_o    (bvalid_o),
    .bready_i    (bready_i),
    .r_o         (r_o),
    .rvalid_o    (rvalid_o),
    .rready_i    (rready_i),
    .req_o       (req_in),
    .req_push_o  (req_push),
    .req_full_i  (req_full),
    .rsp_i       (rsp_head),
    .rsp_empty_i (rsp_empty),
    .rsp_pop_o   (rsp_pop)
  );

  ////////////////////////////////////////
  // Queues
  ////////////////////////////////////////

  sync_fifo #(.T(sys_bus_pkg::bus_req_t)) i_req_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (req_in),
    .push_i  (req_push),
    .pop_i   (req_pop),
    .data_o  (req_head),
    .full_o  (req_full),
    .empty_o (req_empty)
  );

  sync_fifo #(.T(sys_bus_pkg::bus_rsp_t)) i_rsp_fifo (
    .clk_i   (clk_i),
    .rst_i   (rst_i),
    .data_i  (rsp_in),
    .push_i  (rsp_push),
    .pop_i   (rsp_pop),
    .data_o  (rsp_head),
    .full_o  (rsp_full),
    .empty_o (rsp_empty)
  );

  ////////////////////////////////////////
  // System bus side
  ////////////////////////////////////////

  sys_bus_master i_sys_bus_master (
    .clk_i       (clk_i),
    .rst_i       (rst_i),
    .req_i       (req_head),
    .req_empty_i (req_empty),
    .req_pop_o   (req_pop),
    .sys_req_o   (sys_req),
    .sys_rsp_i   (sys_rsp),
    .rsp_o       (rsp_in),
    .rsp_push_o  (rsp_push),
    .rsp_full_i  (rsp_full)
  );

  ctrl_regs i_ctrl_regs (
    .clk_i     (clk_i),
    .rst_i     (rst_i),
    .sys_req_i (sys_req),
    .sys_rsp_o (sys_rsp)
  );

endmodule

// File: tb/tb_ps_axi_bridge.sv
/*
 * Testbench for the AXI to system bus bridge: table of AXI
 * accesses with expected responses, random B/R back-pressure
 */
`timescale 1ns/1ps

`include "sys_bus_defines.svh"

module tb_ps_axi_bridge;

  typedef struct {
    string             name;
    bit                we;
    logic [`SB_IW-1:0] id;
    logic [`SB_AW-1:0] addr;
    logic [`SB_DW-1:0] data;
    logic [3:0]        strb;
    logic [`SB_DW-1:0] exp_data;
    logic [1:0]        exp_resp;
    bit                no_wait;
  } entry_t;

  logic                 clk_i;
  logic                 rst_i;
  sys_bus_pkg::axi_aw_t aw_i;
  logic                 awvalid_i;
  logic                 awready_o;
  sys_bus_pkg::axi_w_t  w_i;
  logic                 wvalid_i;
  logic                 wready_o;
  sys_bus_pkg::axi_ar_t ar_i;
  logic                 arvalid_i;
  logic                 arready_o;
  sys_bus_pkg::axi_b_t  b_o;
  logic                 bvalid_o;
  logic                 bready_i;
  sys_bus_pkg::axi_r_t  r_o;
  logic                 rvalid_o;
  logic                 rready_i;

  entry_t tbl[$];
  int     exp_q[$];
  integer seed = 79004;
  integer rnd;
  int     cycles = 0;
  int     limit = 0;

  ps_axi_bridge i_ps_axi_bridge (.*);

  always #50 clk_i = ~clk_i;

  ////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////

  task automatic stop_run(input string msg);
    $display("%s", msg);
    $display("TEST FAILED");
    $fatal(1);
  endtask

  task automatic check_field(input string name, input string field,
                             input logic [31:0] exp_v, input logic [31:0] act_v);
    assert (exp_v === act_v) else
      stop_run($sformatf("Fail %s %s: expected %h, actual %h", name, field, exp_v, act_v));
  endtask

  // Old bytes kept where the strobe bit is clear
  function automatic logic [31:0] byte_merge(input logic [31:0] old_v,
                                             input logic [31:0] new_v,
                                             input logic [3:0] strb);
    logic [31:0] mask;
    mask = {{8{strb[3]}}, {8{strb[2]}}, {8{strb[1]}}, {8{strb[0]}}};
    return (old_v & ~mask) | (new_v & mask);
  endfunction

  task automatic add_entry(input string name, input bit we, input logic [11:0] id,
                           input logic [31:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, input logic [31:0] exp_data,
                           input logic [1:0] exp_resp, input bit no_wait);
    entry_t e;
    e.name     = name;
    e.we       = we;
    e.id       = id;
    e.addr     = addr;
    e.data     = data;
    e.strb     = strb;
    e.exp_data = exp_data;
    e.exp_resp = exp_resp;
    e.no_wait  = no_wait;
    tbl.push_back(e);
  endtask

  task automatic build_table();
    logic [31:0] part_val;
    logic [31:0] last_val [1:7];
    part_val = byte_merge(32'hdead_beef, 32'h1234_5678, 4'b0101);
    for (int r = 1; r < `SB_REG_NUM; r++) begin
      add_entry($sformatf("reset_read_r%0d", r), 0, 12'(r), 32'(r * 4), 32'h0, 4'h0,
                32'h0, `SB_RESP_OKAY, 0);
    end
    add_entry("id_read", 0, 12'h0a1, 32'h00, 32'h0, 4'h0, `SB_ID_VALUE, `SB_RESP_OKAY, 0);
    add_entry("full_write_r3", 1, 12'h0b2, 32'h0c, 32'hdead_beef, 4'hf, 32'h0,
              `SB_RESP_OKAY, 0);
    add_entry("full_read_r3", 0, 12'h0b3, 32'h0c, 32'h0, 4'h0, 32'hdead_beef,
              `SB_RESP_OKAY, 0);
    add_entry("part_write_r3", 1, 12'h0c4, 32'h0c, 32'h1234_5678, 4'b0101, 32'h0,
              `SB_RESP_OKAY, 0);
    add_entry("part_read_r3", 0, 12'h0c5, 32'h0c, 32'h0, 4'h0, part_val, `SB_RESP_OKAY, 0);
    // Error cases that must leave every register unchanged
    add_entry("id_write", 1, 12'h0d6, 32'h00, 32'hffff_ffff, 4'hf, 32'h0,
              `SB_RESP_SLVERR, 0);
    add_entry("high_read", 0, 12'h0d7, 32'h20, 32'h0, 4'h0, 32'h0, `SB_RESP_SLVERR, 0);
    add_entry("high_write", 1, 12'h0d8, 32'h24, 32'haaaa_5555, 4'hf, 32'h0,
              `SB_RESP_SLVERR, 0);
    add_entry("far_write", 1, 12'h0d9, 32'h1000_000c, 32'h5555_aaaa, 4'hf, 32'h0,
              `SB_RESP_SLVERR, 0);
    add_entry("id_after_err", 0, 12'h0da, 32'h00, 32'h0, 4'h0, `SB_ID_VALUE,
              `SB_RESP_OKAY, 0);
    add_entry("r1_after_err", 0, 12'h0db, 32'h04, 32'h0, 4'h0, 32'h0, `SB_RESP_OKAY, 0);
    add_entry("r3_after_err", 0, 12'h0dc, 32'h0c, 32'h0, 4'h0, part_val, `SB_RESP_OKAY, 0);
    // Back to back writes with r5 written twice
    for (int r = 1; r < `SB_REG_NUM; r++) begin
      last_val[r] = 32'h1111_1111 * 32'(r);
      add_entry($sformatf("burst_write_r%0d", r), 1, 12'h100 + 12'(r), 32'(r * 4),
                last_val[r], 4'hf, 32'h0, `SB_RESP_OKAY, 1);
    end
    last_val[5] = 32'hcafe_0005;
    add_entry("burst_rewrite_r5", 1, 12'h1f5, 32'h14, last_val[5], 4'hf, 32'h0,
              `SB_RESP_OKAY, 1);
    for (int r = 1; r < `SB_REG_NUM; r++) begin
      add_entry($sformatf("burst_read_r%0d", r), 0, 12'h200 + 12'(r), 32'(r * 4),
                32'h0, 4'h0, last_val[r], `SB_RESP_OKAY, 1);
    end
  endtask

  ////////////////////////////////////////
  // AXI master side
  ////////////////////////////////////////

  // Starts and returns on a falling edge
  task automatic issue(input entry_t e);
    logic taken;
    if (e.we) begin
      aw_i.id   = e.id;
      aw_i.addr = e.addr;
      w_i.data  = e.data;
      w_i.strb  = e.strb;
      awvalid_i = 1'b1;
      wvalid_i  = 1'b1;
    end else begin
      ar_i.id   = e.id;
      ar_i.addr = e.addr;
      arvalid_i = 1'b1;
    end
    #1;
    taken = e.we ? (awready_o && wready_o) : arready_o;
    while (!taken) begin
      @(negedge clk_i);
      #1;
      taken = e.we ? (awready_o && wready_o) : arready_o;
    end
    @(negedge clk_i);
    awvalid_i = 1'b0;
    wvalid_i  = 1'b0;
    arvalid_i = 1'b0;
  endtask

  task automatic wait_drain();
    while (exp_q.size() != 0) @(negedge clk_i);
  endtask

  task automatic check_b();
    int idx;
    assert (exp_q.size() > 0) else stop_run("B response arrived with nothing outstanding");
    idx = exp_q.pop_front();
    assert (tbl[idx].we) else
      stop_run($sformatf("B response arrived where read %s was due", tbl[idx].name));
    check_field(tbl[idx].name, "bid", 32'(tbl[idx].id), 32'(b_o.id));
    check_field(tbl[idx].name, "bresp", 32'(tbl[idx].exp_resp), 32'(b_o.resp));
  endtask

  task automatic check_r();
    int idx;
    assert (exp_q.size() > 0) else stop_run("R response arrived with nothing outstanding");
    idx = exp_q.pop_front();
    assert (!tbl[idx].we) else
      stop_run($sformatf("R response arrived where write %s was due", tbl[idx].name));
    check_field(tbl[idx].name, "rid", 32'(tbl[idx].id), 32'(r_o.id));
    check_field(tbl[idx].name, "rresp", 32'(tbl[idx].exp_resp), 32'(r_o.resp));
    check_field(tbl[idx].name, "rdata", tbl[idx].exp_data, r_o.data);
  endtask

  // Random B/R ready, response checks and run limit
  always @(negedge clk_i) begin
    rnd      = $random(seed);
    bready_i = rnd[0];
    rready_i = rnd[1];
    cycles++;
    if (limit > 0 && cycles >= limit) begin
      stop_run($sformatf("Timeout: run still busy after %0d cycles", cycles));
    end
    #1;
    if (bvalid_o && bready_i) check_b();
    if (rvalid_o && rready_i) check_r();
  end

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial begin
    clk_i     = 1'b0;
    rst_i     = 1'b1;
    aw_i      = '0;
    awvalid_i = 1'b0;
    w_i       = '0;
    wvalid_i  = 1'b0;
    ar_i      = '0;
    arvalid_i = 1'b0;
    bready_i  = 1'b0;
    rready_i  = 1'b0;
    build_table();
    limit = 40 * tbl.size() + 20;

    repeat (2) @(negedge clk_i);
    rst_i = 1'b0;
    #1;
    // Ready and valid outputs quiet before any request
    check_field("reset_state", "ready_valid", 32'h0,
                {27'd0, awready_o, wready_o, arready_o, bvalid_o, rvalid_o});
    @(negedge clk_i);

    for (int i = 0; i < tbl.size(); i++) begin
      exp_q.push_back(i);
      issue(tbl[i]);
      if (!tbl[i].no_wait) wait_drain();
    end
    wait_drain();

    $display("TEST OK");
    $finish;
  end

endmodule

// File: src.f
+incdir+verilog
verilog/sys_bus_pkg.sv
verilog/sync_fifo.sv
verilog/axi_slave_front.sv
verilog/sys_bus_master.sv
verilog/ctrl_regs.sv
verilog/ps_axi_bridge.sv
tb/tb_ps_axi_bridge.sv

// File: Makefile
# Verilator build and run for the AXI to system bus bridge

VERILATOR ?= verilator
TOP       ?= tb_ps_axi_bridge
FILELIST  ?= src.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --assert -Wno-fatal

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard verilog/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	@out="$$($(BIN))"; echo "$$out"; echo "$$out" | grep -qx "TEST OK"

clean:
	rm -rf $(OBJ_DIR)
